//--- Makefile
TOP = tb_box_filter

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- bench/tb_box_filter.sv
`timescale 1ns/1ns

module tb_box_filter;
    import img_pkg::*;
    import wb_map_pkg::*;

    localparam int ROWS        = 7;
    localparam int COLS        = 7;
    localparam int RAD         = 3;
    localparam int NPIX        = ROWS * COLS;
    localparam int ACK_LIMIT   = 8;
    localparam int DONE_LIMIT  = 3000;
    localparam int KIND_CONST  = 0;
    localparam int KIND_RAND   = 1;
    localparam int NRUNS       = 10;

    // each column is one run with its image kind, pixel value, probe index and expected sum
    localparam int KIND_TAB  [NRUNS] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 1};
    localparam int VALUE_TAB [NRUNS] = '{1, 1, 10, 3, 7, 2, 255, 255, 0, 0};
    localparam int PROBE_TAB [NRUNS] = '{0, 24, 3, 8, 21, 45, 48, 24, 0, 0};
    localparam int EXP_TAB   [NRUNS] = '{16, 49, 280, 75, 196, 56, 4080, 12495, 0, 0};

    // addresses that read back as zero
    localparam wb_addr_t ZERO_ADDRS [7] = '{12'h000, 12'h008, 12'h3fc, 12'h400,
                                            12'h4c0, 12'hc00, 12'hffc};

    logic     clk = 1'b0;
    logic     rst;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;
    pixel_t   img [NPIX];
    wb_data_t rd;

    box_filter_top #(
        .IMG_ROWS(ROWS),
        .IMG_COLS(COLS),
        .RADIUS  (RAD)
    ) dut (
        .clk     (clk),
        .rst     (rst),
        .wb_cyc_i(wb_cyc),
        .wb_stb_i(wb_stb),
        .wb_we_i (wb_we),
        .wb_adr_i(wb_adr),
        .wb_dat_i(wb_dat_w),
        .wb_dat_o(wb_dat_r),
        .wb_ack_o(wb_ack)
    );

    always #10 clk = ~clk;

    task automatic fail_now(input string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_val(input string what, input wb_data_t got, input wb_data_t exp);
        assert (got == exp) else begin
            fail_now($sformatf("MISMATCH at %0t ns: %s read %0d, expected %0d",
                               $time, what, got, exp));
        end
    endtask

    // drives on the falling edge and returns the word seen in the ack cycle
    task automatic bus_cycle(input logic we, input wb_addr_t addr, input wb_data_t data,
                             output wb_data_t rdata);
        int waits;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_dat_w = data;
        waits    = 0;
        @(negedge clk);
        while (!wb_ack) begin
            waits++;
            if (waits > ACK_LIMIT) begin
                fail_now($sformatf("no ack for the access to address %0h", addr));
            end
            @(negedge clk);
        end
        rdata = wb_dat_r;
        // we, address and data stay put into the cycle that acts on a write
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        @(negedge clk);
        check_val("ack in the cycle after an ack", 32'(wb_ack), 32'h0);
    endtask

    task automatic bus_write(input wb_addr_t addr, input wb_data_t data);
        wb_data_t unused;
        bus_cycle(1'b1, addr, data, unused);
    endtask

    task automatic bus_read(input wb_addr_t addr, output wb_data_t data);
        bus_cycle(1'b0, addr, 32'h0, data);
    endtask

    task automatic wait_done();
        wb_data_t st;
        int polls;
        polls = 0;
        bus_read(STATUS_ADDR, st);
        while (!st[STAT_DONE_BIT]) begin
            polls++;
            if (polls > DONE_LIMIT) begin
                fail_now("the run never reported done");
            end
            bus_read(STATUS_ADDR, st);
        end
        check_val("STATUS at end of run", st, 32'h2);
    endtask

    // zero-padded window sum where taps outside the image add nothing
    function automatic int window_sum(input int idx);
        int r, c, s;
        r = idx / COLS;
        c = idx % COLS;
        s = 0;
        for (int dr = -RAD; dr <= RAD; dr++) begin
            for (int dc = -RAD; dc <= RAD; dc++) begin
                if (r + dr >= 0 && r + dr < ROWS && c + dc >= 0 && c + dc < COLS) begin
                    s += int'(img[(r + dr) * COLS + c + dc]);
                end
            end
        end
        return s;
    endfunction

    task automatic load_image(input int kind, input int value);
        for (int i = 0; i < NPIX; i++) begin
            if (kind == KIND_RAND) begin
                img[i] = pixel_t'($urandom);
            end else begin
                img[i] = pixel_t'(value);
            end
            // junk above bit 7 must not reach the pixel
            bus_write(wb_addr_t'(PIX_BASE + 4 * i), {24'hbad0f0, img[i]});
        end
    endtask

    task automatic start_run();
        wb_data_t st;
        bus_write(CTRL_ADDR, 32'h1);
        bus_read(STATUS_ADDR, st);
        check_val("STATUS after start", st, 32'h1);
    endtask

    task automatic check_results();
        wb_data_t got;
        for (int i = 0; i < NPIX; i++) begin
            bus_read(wb_addr_t'(RES_BASE + 4 * i), got);
            check_val($sformatf("result %0d", i), got, wb_data_t'(window_sum(i)));
        end
    endtask

    initial begin
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        void'($urandom(32'he32e3b5d));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        bus_read(STATUS_ADDR, rd);
        check_val("STATUS after reset", rd, 32'h0);
        for (int i = 0; i < NPIX; i++) begin
            bus_read(wb_addr_t'(RES_BASE + 4 * i), rd);
            check_val($sformatf("result %0d after reset", i), rd, 32'h0);
        end

        for (int t = 0; t < NRUNS; t++) begin
            load_image(KIND_TAB[t], VALUE_TAB[t]);
            start_run();
            wait_done();
            if (KIND_TAB[t] == KIND_CONST) begin
                bus_read(wb_addr_t'(RES_BASE + 4 * PROBE_TAB[t]), rd);
                check_val($sformatf("run %0d probe %0d", t, PROBE_TAB[t]), rd,
                          wb_data_t'(EXP_TAB[t]));
            end
            check_results();
        end

        // the pixel window must still read zero now that pixels are loaded
        for (int i = 0; i < 7; i++) begin
            bus_read(ZERO_ADDRS[i], rd);
            check_val($sformatf("read of address %0h", ZERO_ADDRS[i]), rd, 32'h0);
        end

        // done from the last run is cleared by this start
        load_image(KIND_RAND, 0);
        start_run();
        bus_write(CTRL_ADDR, 32'h1);
        for (int i = 0; i < NPIX; i++) begin
            bus_write(wb_addr_t'(PIX_BASE + 4 * i), wb_data_t'(~img[i]));
        end
        bus_read(STATUS_ADDR, rd);
        check_val("STATUS while disturbed", rd, 32'h1);
        wait_done();
        check_results();

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- flist.f
hw/img_pkg.sv
hw/wb_map_pkg.sv
hw/wb_reg_decode.sv
hw/window_accum.sv
hw/result_store.sv
hw/box_filter_top.sv
bench/tb_box_filter.sv

//--- hw/box_filter_top.sv
`timescale 1ns/1ns

module box_filter_top #(
    parameter int IMG_ROWS = 7,
    parameter int IMG_COLS = 7,
    parameter int RADIUS   = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  wb_map_pkg::wb_addr_t wb_adr_i,
    input  wb_map_pkg::wb_data_t wb_dat_i,
    output wb_map_pkg::wb_data_t wb_dat_o,
    output logic                 wb_ack_o
);
    import img_pkg::*;

    logic     start;
    logic     pix_we;
    logic     busy;
    logic     res_we;
    logic     done;
    pix_idx_t pix_addr;
    pix_idx_t res_addr;
    pix_idx_t rd_addr;
    pixel_t   pix_data;
    sum_t     res_data;
    sum_t     rd_data;

    wb_reg_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .busy_i    (busy),
        .done_i    (done),
        .rd_data_i (rd_data),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .start_o   (start),
        .pix_we_o  (pix_we),
        .pix_addr_o(pix_addr),
        .pix_data_o(pix_data),
        .rd_addr_o (rd_addr)
    );

    window_accum #(
        .IMG_ROWS(IMG_ROWS),
        .IMG_COLS(IMG_COLS),
        .RADIUS  (RADIUS)
    ) u_accum (
        .clk       (clk),
        .rst       (rst),
        .start_i   (start),
        .pix_we_i  (pix_we),
        .pix_addr_i(pix_addr),
        .pix_data_i(pix_data),
        .busy_o    (busy),
        .res_we_o  (res_we),
        .res_addr_o(res_addr),
        .res_data_o(res_data)
    );

    result_store #(
        .IMG_ROWS(IMG_ROWS),
        .IMG_COLS(IMG_COLS)
    ) u_store (
        .clk       (clk),
        .rst       (rst),
        .start_i   (start),
        .res_we_i  (res_we),
        .res_addr_i(res_addr),
        .res_data_i(res_data),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data),
        .done_o    (done)
    );

endmodule

//--- hw/img_pkg.sv
package img_pkg;

    // sample and accumulator widths
    localparam int PIX_W   = 8;
    localparam int SUM_W   = 16;

    // signed so that taps left of or above the image stay negative
    localparam int COORD_W = 9;

    // row-major linear index into the pixel and result memories
    localparam int IDX_W   = 12;

    typedef logic [PIX_W-1:0] pixel_t;

    // wide enough for a 15x15 window of full-scale pixels
    typedef logic [SUM_W-1:0] sum_t;

    typedef logic signed [COORD_W-1:0] coord_t;

    typedef logic [IDX_W-1:0] pix_idx_t;

endpackage

//--- hw/result_store.sv
`timescale 1ns/1ns

module result_store #(
    parameter int IMG_ROWS = 7,
    parameter int IMG_COLS = 7
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_i,
    input  logic              res_we_i,
    input  img_pkg::pix_idx_t res_addr_i,
    input  img_pkg::sum_t     res_data_i,
    input  img_pkg::pix_idx_t rd_addr_i,
    output img_pkg::sum_t     rd_data_o,
    output logic              done_o
);
    import img_pkg::*;

    localparam int       NPIX     = IMG_ROWS * IMG_COLS;
    localparam int       AW       = $clog2(NPIX);
    localparam pix_idx_t LAST_IDX = pix_idx_t'(NPIX - 1);

    sum_t res_mem [NPIX];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NPIX; i++) begin
                res_mem[i] <= '0;
            end
        end else if (res_we_i && res_addr_i < pix_idx_t'(NPIX)) begin
            res_mem[res_addr_i[AW-1:0]] <= res_data_i;
        end
    end

    // done follows the write of the last result and a new run clears it
    always_ff @(posedge clk) begin
        if (rst) begin
            done_o <= 1'b0;
        end else if (start_i) begin
            done_o <= 1'b0;
        end else if (res_we_i && res_addr_i == LAST_IDX) begin
            done_o <= 1'b1;
        end
    end

    // words past the image read as zero
    assign rd_data_o = (rd_addr_i < pix_idx_t'(NPIX)) ? res_mem[rd_addr_i[AW-1:0]] : '0;

    // the accumulator never walks past the last pixel
    assert property (@(posedge clk) disable iff (rst)
        res_we_i |-> res_addr_i < pix_idx_t'(NPIX));

endmodule

//--- hw/wb_map_pkg.sv
package wb_map_pkg;

    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] wb_addr_t;
    typedef logic [DATA_W-1:0] wb_data_t;

    // register words
    localparam wb_addr_t CTRL_ADDR   = 12'h000;
    localparam wb_addr_t STATUS_ADDR = 12'h004;

    // 1 KiB windows holding one word per pixel or result
    localparam wb_addr_t PIX_BASE = 12'h400;
    localparam wb_addr_t RES_BASE = 12'h800;

    // bit positions inside CTRL and STATUS
    localparam int CTRL_START_BIT = 0;
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;

endpackage

//--- hw/wb_reg_decode.sv
`timescale 1ns/1ns

module wb_reg_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  wb_map_pkg::wb_addr_t wb_adr_i,
    input  wb_map_pkg::wb_data_t wb_dat_i,
    input  logic                 busy_i,
    input  logic                 done_i,
    input  img_pkg::sum_t        rd_data_i,
    output wb_map_pkg::wb_data_t wb_dat_o,
    output logic                 wb_ack_o,
    output logic                 start_o,
    output logic                 pix_we_o,
    output img_pkg::pix_idx_t    pix_addr_o,
    output img_pkg::pixel_t      pix_data_o,
    output img_pkg::pix_idx_t    rd_addr_o
);
    import wb_map_pkg::*;
    import img_pkg::*;

    logic     active;
    logic     is_ctrl;
    logic     is_status;
    logic     is_pix;
    logic     is_res;
    logic     wr_ack;
    pix_idx_t word_idx;
    wb_data_t status_word;

    assign active = wb_cyc_i && wb_stb_i;

    // ack one cycle after the request is seen and then drop it
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= active && !wb_ack_o;
        end
    end

    // region select on the top two address bits with registers matched exactly
    assign is_ctrl   = (wb_adr_i == CTRL_ADDR);
    assign is_status = (wb_adr_i == STATUS_ADDR);
    assign is_pix    = (wb_adr_i[11:10] == PIX_BASE[11:10]);
    assign is_res    = (wb_adr_i[11:10] == RES_BASE[11:10]);
    assign word_idx  = pix_idx_t'(wb_adr_i[9:2]);

    // write side effects line up with the ack cycle
    assign wr_ack   = wb_ack_o && wb_we_i;
    // a start during a run never leaves the decoder
    assign start_o  = wr_ack && is_ctrl && wb_dat_i[CTRL_START_BIT] && !busy_i;
    assign pix_we_o = wr_ack && is_pix;

    assign pix_addr_o = word_idx;
    assign pix_data_o = wb_dat_i[7:0];
    assign rd_addr_o  = word_idx;

    always_comb begin
        status_word = '0;
        status_word[STAT_BUSY_BIT] = busy_i;
        status_word[STAT_DONE_BIT] = done_i;
    end

    // pixel window and unmapped words read back as zero
    always_comb begin
        if (is_status) begin
            wb_dat_o = status_word;
        end else if (is_res) begin
            wb_dat_o = wb_data_t'(rd_data_i);
        end else begin
            wb_dat_o = '0;
        end
    end

    // ack never stays high for two cycles in a row
    assert property (@(posedge clk) disable iff (rst)
        wb_ack_o |=> !wb_ack_o);

endmodule

//--- hw/window_accum.sv
`timescale 1ns/1ns

module window_accum #(
    parameter int IMG_ROWS = 7,
    parameter int IMG_COLS = 7,
    parameter int RADIUS   = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_i,
    input  logic              pix_we_i,
    input  img_pkg::pix_idx_t pix_addr_i,
    input  img_pkg::pixel_t   pix_data_i,
    output logic              busy_o,
    output logic              res_we_o,
    output img_pkg::pix_idx_t res_addr_o,
    output img_pkg::sum_t     res_data_o
);
    import img_pkg::*;

    localparam int       NPIX     = IMG_ROWS * IMG_COLS;
    localparam int       AW       = $clog2(NPIX);
    localparam coord_t   OFF_MIN  = coord_t'(-RADIUS);
    localparam coord_t   OFF_MAX  = coord_t'(RADIUS);
    localparam coord_t   COL_LAST = coord_t'(IMG_COLS - 1);
    localparam pix_idx_t LAST_IDX = pix_idx_t'(NPIX - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ACC,
        S_WRITE
    } state_t;

    state_t   state;
    pixel_t   pix_mem [NPIX];
    coord_t   ctr_row;
    coord_t   ctr_col;
    coord_t   off_row;
    coord_t   off_col;
    coord_t   tap_row;
    coord_t   tap_col;
    pix_idx_t ctr_idx;
    pix_idx_t tap_idx;
    logic     tap_in;
    pixel_t   tap_pix;
    sum_t     acc;

    // image is loaded only between runs
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NPIX; i++) begin
                pix_mem[i] <= '0;
            end
        end else if (pix_we_i && state == S_IDLE && pix_addr_i < pix_idx_t'(NPIX)) begin
            pix_mem[pix_addr_i[AW-1:0]] <= pix_data_i;
        end
    end

    // current tap reads zero when it falls in the padding
    always_comb begin
        tap_row = ctr_row + off_row;
        tap_col = ctr_col + off_col;
        tap_in  = (tap_row >= 0) && (tap_row < IMG_ROWS) &&
                  (tap_col >= 0) && (tap_col < IMG_COLS);
        tap_idx = pix_idx_t'(tap_row) * pix_idx_t'(IMG_COLS) + pix_idx_t'(tap_col);
        tap_pix = tap_in ? pix_mem[tap_idx[AW-1:0]] : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            ctr_row <= '0;
            ctr_col <= '0;
            ctr_idx <= '0;
            off_row <= OFF_MIN;
            off_col <= OFF_MIN;
            acc     <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        state   <= S_ACC;
                        ctr_row <= '0;
                        ctr_col <= '0;
                        ctr_idx <= '0;
                        off_row <= OFF_MIN;
                        off_col <= OFF_MIN;
                        acc     <= '0;
                    end
                end
                S_ACC: begin
                    acc <= acc + sum_t'(tap_pix);
                    // column offset runs fastest
                    if (off_col == OFF_MAX) begin
                        off_col <= OFF_MIN;
                        if (off_row == OFF_MAX) begin
                            off_row <= OFF_MIN;
                            state   <= S_WRITE;
                        end else begin
                            off_row <= off_row + coord_t'(1);
                        end
                    end else begin
                        off_col <= off_col + coord_t'(1);
                    end
                end
                S_WRITE: begin
                    acc     <= '0;
                    ctr_idx <= ctr_idx + 1'b1;
                    if (ctr_col == COL_LAST) begin
                        ctr_col <= '0;
                        ctr_row <= ctr_row + coord_t'(1);
                    end else begin
                        ctr_col <= ctr_col + coord_t'(1);
                    end
                    state <= (ctr_idx == LAST_IDX) ? S_IDLE : S_ACC;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    assign busy_o     = (state != S_IDLE);
    assign res_we_o   = (state == S_WRITE);
    assign res_addr_o = ctr_idx;
    assign res_data_o = acc;

    // offsets stay inside the window for the whole run
    assert property (@(posedge clk) disable iff (rst)
        busy_o |-> (off_row >= OFF_MIN) && (off_row <= OFF_MAX) &&
                   (off_col >= OFF_MIN) && (off_col <= OFF_MAX));

    // a result is only written once a run has been under way for at least a cycle
    assert property (@(posedge clk) disable iff (rst)
        res_we_o |-> busy_o && $past(busy_o));

endmodule
